//--- include/rob_defs.svh
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// window size and retire width
`define ROB_LENGTH 16
`define ROB_WIDTH 2

// field widths
`define SQN_BITS 6
`define TAG_BITS 6
`define NAME_BITS 5

// APB register offsets with map entries one word apart
`define ROB_ADDR_STATUS 32'h0000_0000
`define ROB_ADDR_COUNT 32'h0000_0004
`define ROB_ADDR_CONTROL 32'h0000_0008
`define ROB_ADDR_MAP 32'h0000_0100

`endif

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f verilog.f --top-module robTb -o robSim

if ! ./obj_dir/robSim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi
cat sim.log

if grep -q "Done: errors found" sim.log; then
    exit 1
fi

//--- source/reorderBuffer.sv
`include "rob_defs.svh"

module reorderBuffer (
    input logic clk,
    input logic rst,
    input uopPkg::ResultUop results [`ROB_WIDTH],
    input logic invalidate,
    input logic [`SQN_BITS-1:0] invalidateSqN,
    output retirePkg::CommitSlot commit [`ROB_WIDTH],
    output logic [`SQN_BITS-1:0] curSqN,
    output logic [`SQN_BITS-1:0] maxSqN,
    output logic halt
);

    localparam int idxBits = $clog2(`ROB_LENGTH);
    localparam int cntBits = $clog2(`ROB_WIDTH + 1);

    // slot of an op is its sqN modulo the window length
    uopPkg::RobEntry entries [`ROB_LENGTH];

    logic [idxBits-1:0] curIdx;
    logic [idxBits-1:0] headIdx [`ROB_WIDTH];
    logic [`SQN_BITS-1:0] slotSqN [`ROB_LENGTH];
    logic [`SQN_BITS-1:0] accOffset [`ROB_WIDTH];
    logic [`ROB_WIDTH-1:0] retireMask;
    logic [`ROB_WIDTH-1:0] accept;
    logic [`ROB_WIDTH-1:0] commitValid;
    logic [cntBits-1:0] retireCnt;
    logic retireFlag;

    // true when a is strictly younger than b
    function automatic logic isNewer(input logic [`SQN_BITS-1:0] a,
                                     input logic [`SQN_BITS-1:0] b);
        logic [`SQN_BITS-1:0] diff;
        diff = a - b;
        return !diff[`SQN_BITS-1] && (diff != '0);
    endfunction

    assign curIdx = curSqN[idxBits-1:0];
    assign maxSqN = curSqN + `SQN_BITS'(`ROB_LENGTH - 1);

    // sqN currently mapped onto each slot
    always_comb begin
        logic [idxBits-1:0] ofs;
        for (int i = 0; i < `ROB_LENGTH; i++) begin
            ofs = idxBits'(i) - curIdx;
            slotSqN[i] = curSqN + `SQN_BITS'(ofs);
        end
    end

    // longest run of ready head entries, cut after a flagged op
    always_comb begin
        logic stop;
        stop = halt || invalidate;
        retireMask = '0;
        retireCnt = '0;
        retireFlag = 1'b0;
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            headIdx[k] = curIdx + idxBits'(k);
            if (!stop && entries[headIdx[k]].valid) begin
                retireMask[k] = 1'b1;
                retireCnt = retireCnt + 1'b1;
                if (entries[headIdx[k]].flags) begin
                    retireFlag = 1'b1;
                end
                stop = entries[headIdx[k]].flags;
            end else begin
                stop = 1'b1;
            end
        end
    end

    // arriving ops younger than a branch being recovered are dropped
    always_comb begin
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            accOffset[k] = results[k].sqN - curSqN;
            accept[k] = results[k].valid &&
                        !(invalidate && isNewer(results[k].sqN, invalidateSqN));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            curSqN <= '0;
            halt <= 1'b0;
            for (int i = 0; i < `ROB_LENGTH; i++) begin
                entries[i].valid <= 1'b0;
            end
            for (int k = 0; k < `ROB_WIDTH; k++) begin
                commit[k].valid <= 1'b0;
            end
        end else begin
            for (int k = 0; k < `ROB_WIDTH; k++) begin
                commit[k].valid <= retireMask[k];
                commit[k].name <= entries[headIdx[k]].name;
                commit[k].tag <= entries[headIdx[k]].tag;
                commit[k].sqN <= curSqN + `SQN_BITS'(k);
                if (retireMask[k]) begin
                    entries[headIdx[k]].valid <= 1'b0;
                end
            end
            curSqN <= curSqN + `SQN_BITS'(retireCnt);
            if (retireFlag) begin
                halt <= 1'b1;
            end

            if (invalidate) begin
                for (int i = 0; i < `ROB_LENGTH; i++) begin
                    if (isNewer(slotSqN[i], invalidateSqN)) begin
                        entries[i].valid <= 1'b0;
                    end
                end
            end

            for (int k = 0; k < `ROB_WIDTH; k++) begin
                if (accept[k]) begin
                    entries[results[k].sqN[idxBits-1:0]] <= '{
                        valid: 1'b1,
                        flags: results[k].flags,
                        tag: results[k].tagDst,
                        name: results[k].nmDst
                    };
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            commitValid[k] = commit[k].valid;
        end
    end

    // producers must stay inside the published window and not reuse a live sqN
    for (genvar k = 0; k < `ROB_WIDTH; k++) begin : gAcceptCheck
        assert property (@(posedge clk) disable iff (rst)
            accept[k] |-> (accOffset[k] < `ROB_LENGTH) &&
                          !entries[results[k].sqN[idxBits-1:0]].valid);
    end

    assert property (@(posedge clk) disable iff (rst)
        (commitValid & (commitValid + 1'b1)) == '0);

    // halted core stays quiet
    assert property (@(posedge clk) disable iff (rst)
        halt |=> commitValid == '0);

endmodule

//--- source/retireMap.sv
`include "rob_defs.svh"

module retireMap (
    input logic clk,
    input logic rst,
    input retirePkg::CommitSlot commit [`ROB_WIDTH],
    input logic [`NAME_BITS-1:0] readName,
    output logic [`TAG_BITS-1:0] readTag
);

    localparam int nameCount = 1 << `NAME_BITS;

    // last committed physical tag per architectural name
    logic [`TAG_BITS-1:0] tagTable [nameCount];
    logic [`ROB_WIDTH-1:0] commitValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int n = 0; n < nameCount; n++) begin
                tagTable[n] <= '0;
            end
        end else begin
            // later slot is younger, so it overrides
            for (int k = 0; k < `ROB_WIDTH; k++) begin
                if (commit[k].valid) begin
                    tagTable[commit[k].name] <= commit[k].tag;
                end
            end
        end
    end

    assign readTag = tagTable[readName];

    always_comb begin
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            commitValid[k] = commit[k].valid;
        end
    end

    // slot order only means program order if there are no holes
    assert property (@(posedge clk) disable iff (rst)
        (commitValid & (commitValid + 1'b1)) == '0);

endmodule

//--- source/retirePkg.sv
`include "rob_defs.svh"

package retirePkg;

    // one op leaving the window in program order
    typedef struct packed {
        logic valid;
        logic [`NAME_BITS-1:0] name;
        logic [`TAG_BITS-1:0] tag;
        logic [`SQN_BITS-1:0] sqN;
    } CommitSlot;

    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        logic [31:0] paddr;
        logic [31:0] pwdata;
    } ApbReq;

    typedef struct packed {
        logic [31:0] prdata;
        logic pready;
        logic pslverr;
    } ApbRsp;

endpackage

//--- source/robStatusApb.sv
`include "rob_defs.svh"

module robStatusApb (
    input logic clk,
    input logic rst,
    input retirePkg::ApbReq apbReq,
    input retirePkg::CommitSlot commit [`ROB_WIDTH],
    input logic [`SQN_BITS-1:0] curSqN,
    input logic [`SQN_BITS-1:0] maxSqN,
    input logic halt,
    input logic [`TAG_BITS-1:0] mapTag,
    output retirePkg::ApbRsp apbRsp,
    output logic [`NAME_BITS-1:0] mapName
);

    localparam int mapLsb = `NAME_BITS + 2;
    localparam logic [31:0] mapBase = `ROB_ADDR_MAP;
    localparam int cntBits = $clog2(`ROB_WIDTH + 1);

    logic [31:0] committedCount;
    logic [cntBits-1:0] commitCnt;
    logic [31:0] rdData;
    logic isStatus;
    logic isCount;
    logic isControl;
    logic isMap;
    logic access;
    logic clearReq;

    assign access = apbReq.psel && apbReq.penable;
    assign isStatus = apbReq.paddr[31:2] == `ROB_ADDR_STATUS >> 2;
    assign isCount = apbReq.paddr[31:2] == `ROB_ADDR_COUNT >> 2;
    assign isControl = apbReq.paddr[31:2] == `ROB_ADDR_CONTROL >> 2;
    assign isMap = apbReq.paddr[31:mapLsb] == mapBase[31:mapLsb];

    // one map entry per word
    assign mapName = apbReq.paddr[mapLsb-1:2];

    assign clearReq = access && apbReq.pwrite && isControl && apbReq.pwdata[0];

    always_comb begin
        commitCnt = '0;
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            commitCnt = commitCnt + cntBits'(commit[k].valid);
        end
    end

    // clear wins over the same-cycle increment
    always_ff @(posedge clk) begin
        if (rst || clearReq) begin
            committedCount <= '0;
        end else begin
            committedCount <= committedCount + 32'(commitCnt);
        end
    end

    always_comb begin
        rdData = '0;
        if (isStatus) begin
            rdData[31] = halt;
            rdData[8 +: `SQN_BITS] = maxSqN;
            rdData[0 +: `SQN_BITS] = curSqN;
        end else if (isCount) begin
            rdData = committedCount;
        end else if (isMap) begin
            rdData[`TAG_BITS-1:0] = mapTag;
        end
    end

    assign apbRsp.prdata = rdData;
    assign apbRsp.pready = 1'b1;
    // unmapped address, or a write to anything but CONTROL
    assign apbRsp.pslverr = access &&
                            (!(isStatus || isCount || isControl || isMap) ||
                             (apbReq.pwrite && !isControl));

    assert property (@(posedge clk) disable iff (rst)
        apbReq.penable |-> apbReq.psel);

endmodule

//--- source/robSubsystem.sv
`include "rob_defs.svh"

module robSubsystem (
    input logic clk,
    input logic rst,
    input uopPkg::ResultUop results [`ROB_WIDTH],
    input logic invalidate,
    input logic [`SQN_BITS-1:0] invalidateSqN,
    input retirePkg::ApbReq apbReq,
    output retirePkg::CommitSlot commit [`ROB_WIDTH],
    output logic [`SQN_BITS-1:0] curSqN,
    output logic [`SQN_BITS-1:0] maxSqN,
    output logic halt,
    output retirePkg::ApbRsp apbRsp
);

    // map readout path between the register block and the table
    logic [`NAME_BITS-1:0] mapName;
    logic [`TAG_BITS-1:0] mapTag;

    reorderBuffer rob0 (
        .clk(clk),
        .rst(rst),
        .results(results),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .commit(commit),
        .curSqN(curSqN),
        .maxSqN(maxSqN),
        .halt(halt)
    );

    retireMap map0 (
        .clk(clk),
        .rst(rst),
        .commit(commit),
        .readName(mapName),
        .readTag(mapTag)
    );

    robStatusApb apb0 (
        .clk(clk),
        .rst(rst),
        .apbReq(apbReq),
        .commit(commit),
        .curSqN(curSqN),
        .maxSqN(maxSqN),
        .halt(halt),
        .mapTag(mapTag),
        .apbRsp(apbRsp),
        .mapName(mapName)
    );

endmodule

//--- source/uopPkg.sv
`include "rob_defs.svh"

package uopPkg;

    // finished op as delivered by an execution unit
    typedef struct packed {
        logic valid;
        logic flags;
        logic [`SQN_BITS-1:0] sqN;
        logic [`TAG_BITS-1:0] tagDst;
        logic [`NAME_BITS-1:0] nmDst;
        logic [31:0] pc;
    } ResultUop;

    // one slot of the reorder window
    typedef struct packed {
        logic valid;
        logic flags;
        logic [`TAG_BITS-1:0] tag;
        logic [`NAME_BITS-1:0] name;
    } RobEntry;

endpackage

//--- test/robTb.sv
`include "rob_defs.svh"

module robTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int totalOps = 400;
    localparam int cycleLimit = 8 * totalOps + 300;
    localparam int sqnMod = 1 << `SQN_BITS;
    localparam int nameCount = 1 << `NAME_BITS;

    logic clk;
    logic rst;
    uopPkg::ResultUop results [`ROB_WIDTH];
    logic invalidate;
    logic [`SQN_BITS-1:0] invalidateSqN;
    retirePkg::ApbReq apbReq;
    retirePkg::CommitSlot commit [`ROB_WIDTH];
    logic [`SQN_BITS-1:0] curSqN;
    logic [`SQN_BITS-1:0] maxSqN;
    logic halt;
    retirePkg::ApbRsp apbRsp;

    // reference model of op contents by sqN
    logic [`NAME_BITS-1:0] opName [sqnMod];
    logic [`TAG_BITS-1:0] opTag [sqnMod];
    logic opFlag [sqnMod];
    logic opPresent [sqnMod];
    logic [`TAG_BITS-1:0] mapModel [nameCount];
    // issued but undelivered ops by absolute program position
    int pool [$];
    int nextAbs;
    int issueAbs;
    int committed;
    int countBase;
    logic haltSeen;
    int seed;
    int cycles;
    int checks;
    int errors;
    int testErrors;

    robSubsystem dut0 (
        .clk(clk),
        .rst(rst),
        .results(results),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .apbReq(apbReq),
        .commit(commit),
        .curSqN(curSqN),
        .maxSqN(maxSqN),
        .halt(halt),
        .apbRsp(apbRsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic checkValue(input string sig, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("FAIL at %0t: %s expected %0d, got %0d", $time, sig, expected, actual);
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("ERROR at %0t: %s", $time, what);
        end
    endtask

    task automatic finishTest(input string name);
        $display("test %s: %0d errors", name, errors - testErrors);
        testErrors = errors;
    endtask

    task automatic clearInputs();
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            results[k] = '0;
        end
        invalidate = 1'b0;
        invalidateSqN = '0;
    endtask

    // commit slots registered at the last rising edge
    task automatic checkCommits();
        logic gap;
        int sq;
        gap = 1'b0;
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            if (commit[k].valid) begin
                sq = nextAbs % sqnMod;
                checkTrue(!gap, "commit slot valid above an invalid slot");
                checkTrue(!haltSeen, "commit slot valid after the halting op");
                checkTrue(opPresent[sq], "retired an op that was invalidated or never sent");
                checkValue($sformatf("commit[%0d].sqN", k), sq, int'(commit[k].sqN));
                checkValue($sformatf("commit[%0d].name", k), int'(opName[sq]),
                           int'(commit[k].name));
                checkValue($sformatf("commit[%0d].tag", k), int'(opTag[sq]),
                           int'(commit[k].tag));
                mapModel[opName[sq]] = opTag[sq];
                opPresent[sq] = 1'b0;
                committed++;
                nextAbs++;
                if (opFlag[sq]) begin
                    haltSeen = 1'b1;
                end
            end else begin
                gap = 1'b1;
            end
        end
        checkValue("halt", int'(haltSeen), int'(halt));
        checkValue("curSqN", nextAbs % sqnMod, int'(curSqN));
        checkValue("maxSqN", (nextAbs + `ROB_LENGTH - 1) % sqnMod, int'(maxSqN));
    endtask

    task automatic driveCycle(input int target, input logic allowInv);
        int n;
        int pick;
        int abs;
        int sq;
        int invAbs;
        clearInputs();
        // keep every issued op inside the published window
        while (issueAbs < target && issueAbs - nextAbs < `ROB_LENGTH) begin
            sq = issueAbs % sqnMod;
            opName[sq] = `NAME_BITS'($random(seed));
            opTag[sq] = `TAG_BITS'($random(seed));
            opFlag[sq] = 1'b0;
            pool.push_back(issueAbs);
            issueAbs++;
        end
        n = randBelow(`ROB_WIDTH + 1);
        for (int k = 0; k < n && pool.size() > 0; k++) begin
            pick = randBelow(pool.size());
            abs = pool[pick];
            pool.delete(pick);
            sq = abs % sqnMod;
            results[k] = '{valid: 1'b1, flags: opFlag[sq], sqN: `SQN_BITS'(sq),
                           tagDst: opTag[sq], nmDst: opName[sq], pc: $random(seed)};
            opPresent[sq] = 1'b1;
        end
        if (allowInv && !haltSeen && issueAbs > nextAbs && randBelow(12) == 0) begin
            // squash back to a random point, then reissue those sqNs
            invAbs = nextAbs - 1 + randBelow(issueAbs - nextAbs + 1);
            invalidate = 1'b1;
            invalidateSqN = `SQN_BITS'(invAbs);
            for (int a = invAbs + 1; a < issueAbs; a++) begin
                opPresent[a % sqnMod] = 1'b0;
            end
            for (int i = pool.size() - 1; i >= 0; i--) begin
                if (pool[i] > invAbs) begin
                    pool.delete(i);
                end
            end
            issueAbs = invAbs + 1;
        end
    endtask

    task automatic runOps(input int target, input logic allowInv);
        while (nextAbs < target) begin
            @(negedge clk);
            checkCommits();
            if (nextAbs < target) begin
                driveCycle(target, allowInv);
            end else begin
                clearInputs();
            end
        end
    endtask

    task automatic apbAccess(input logic write, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
        @(negedge clk);
        apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(negedge clk);
        apbReq.penable = 1'b1;
        #1;
        rdata = apbRsp.prdata;
        err = apbRsp.pslverr;
        checkTrue(apbRsp.pready, "pready low in an access phase");
        @(negedge clk);
        apbReq = '0;
    endtask

    task automatic checkStatus();
        logic [31:0] data;
        logic err;
        apbAccess(1'b0, `ROB_ADDR_STATUS, '0, data, err);
        checkValue("STATUS.halt", int'(haltSeen), int'(data[31]));
        checkValue("STATUS.maxSqN", (nextAbs + `ROB_LENGTH - 1) % sqnMod, int'(data[13:8]));
        checkValue("STATUS.curSqN", nextAbs % sqnMod, int'(data[5:0]));
        checkValue("STATUS pslverr", 0, int'(err));
    endtask

    task automatic checkCount(input int expected);
        logic [31:0] data;
        logic err;
        apbAccess(1'b0, `ROB_ADDR_COUNT, '0, data, err);
        checkValue("COUNT", expected, int'(data));
        checkValue("COUNT pslverr", 0, int'(err));
    endtask

    task automatic checkMap();
        logic [31:0] data;
        logic err;
        for (int n = 0; n < nameCount; n++) begin
            apbAccess(1'b0, `ROB_ADDR_MAP + 32'(4 * n), '0, data, err);
            checkValue($sformatf("map[%0d]", n), int'(mapModel[n]), int'(data));
        end
    endtask

    initial begin
        logic [31:0] data;
        logic err;
        int sq;
        seed = 32'hd9902762;
        cycles = 0;
        checks = 0;
        errors = 0;
        testErrors = 0;
        nextAbs = 0;
        issueAbs = 0;
        committed = 0;
        haltSeen = 1'b0;
        for (int i = 0; i < sqnMod; i++) begin
            opPresent[i] = 1'b0;
            opFlag[i] = 1'b0;
        end
        for (int n = 0; n < nameCount; n++) begin
            mapModel[n] = '0;
        end
        rst = 1'b1;
        apbReq = '0;
        clearInputs();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkCommits();
        finishTest("reset");

        runOps(150, 1'b0);
        finishTest("in-order retirement");

        checkStatus();
        checkCount(committed);
        apbAccess(1'b1, `ROB_ADDR_STATUS, 32'h1, data, err);
        checkValue("pslverr on STATUS write", 1, int'(err));
        apbAccess(1'b0, 32'h40, '0, data, err);
        checkValue("pslverr on unmapped read", 1, int'(err));
        finishTest("apb status and errors");

        checkMap();
        finishTest("retirement map");

        apbAccess(1'b1, `ROB_ADDR_CONTROL, 32'h1, data, err);
        checkValue("pslverr on CONTROL write", 0, int'(err));
        countBase = committed;
        runOps(250, 1'b0);
        checkCount(committed - countBase);
        finishTest("counter clear");

        runOps(totalOps - 1, 1'b1);
        finishTest("invalidate");

        // the final flagged op arrives together with a younger op that must not retire
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            checkCommits();
            clearInputs();
            if (c == 0) begin
                for (int k = 0; k < `ROB_WIDTH; k++) begin
                    sq = (nextAbs + k) % sqnMod;
                    opName[sq] = `NAME_BITS'($random(seed));
                    opTag[sq] = `TAG_BITS'($random(seed));
                    opFlag[sq] = (k == 0);
                    opPresent[sq] = 1'b1;
                    results[k] = '{valid: 1'b1, flags: opFlag[sq], sqN: `SQN_BITS'(sq),
                                   tagDst: opTag[sq], nmDst: opName[sq], pc: '0};
                end
            end
        end
        checkTrue(haltSeen, "halting op never retired");
        finishTest("halt");

        checkStatus();
        checkCount(committed - countBase);
        checkMap();
        finishTest("final status and map");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
source/uopPkg.sv
source/retirePkg.sv
source/reorderBuffer.sv
source/retireMap.sv
source/robStatusApb.sv
source/robSubsystem.sv
test/robTb.sv
